/* Bender.yml */
package:
  name: muldiv_unit

sources:
  - muldiv_pkg.sv
  - booth_multiplier.sv
  - restoring_divider.sv
  - muldiv_dispatch.sv
  - muldiv_unit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_muldiv_unit.sv

/* booth_multiplier.sv */
`default_nettype none

// iterative radix-4 booth multiplier
// one booth digit retired per cycle, full 128-bit product
module booth_multiplier (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    start,
	input  wire                    flush,
	input  wire                    word,
	input  wire                    sign_a,
	input  wire                    sign_b,
	input  wire muldiv_pkg::xlen_t multiplicand,
	input  wire muldiv_pkg::xlen_t multiplier,
	output logic                   busy,
	output logic                   done,
	output muldiv_pkg::xlen_t      product_hi,
	output muldiv_pkg::xlen_t      product_lo
);

	typedef enum logic [1:0] {
		s_idle,
		s_run,
		s_done
	} state_e;

	state_e state_q;

	// operands widened by two bits so unsigned values stay positive
	logic [muldiv_pkg::xlen+1:0] a_ext;
	logic [muldiv_pkg::xlen+1:0] b_ext;

	// captured multiplicand
	logic [muldiv_pkg::xlen+1:0] mcand_q;
	// multiplier, shifted out two bits per step, product low bits shift in
	logic [muldiv_pkg::xlen+1:0] mplr_q;
	// upper partial product, two guard bits over the multiplicand
	logic [muldiv_pkg::xlen+3:0] acc_q;
	// booth bit to the right of the current pair
	logic                        prev_q;
	logic [5:0]                  cnt_q;
	logic                        word_q;

	logic [muldiv_pkg::xlen+3:0] mcand_sx;
	logic [muldiv_pkg::xlen+3:0] pp;
	logic [muldiv_pkg::xlen+3:0] sum;

	// ******************************************************************
	// operand extension
	// ******************************************************************
	always_comb begin
		if (word) begin
			// low word only, sign or zero extended to 66 bits
			a_ext = {{(muldiv_pkg::xlen+2-muldiv_pkg::half_xlen){sign_a & multiplicand[31]}},
				multiplicand[muldiv_pkg::half_xlen-1:0]};
			b_ext = {{(muldiv_pkg::xlen+2-muldiv_pkg::half_xlen){sign_b & multiplier[31]}},
				multiplier[muldiv_pkg::half_xlen-1:0]};
		end else begin
			a_ext = {{2{sign_a & multiplicand[muldiv_pkg::xlen-1]}}, multiplicand};
			b_ext = {{2{sign_b & multiplier[muldiv_pkg::xlen-1]}}, multiplier};
		end
	end

	// ******************************************************************
	// booth recoding of {b[i+1], b[i], b[i-1]}
	// ******************************************************************
	always_comb begin
		mcand_sx = {{2{mcand_q[muldiv_pkg::xlen+1]}}, mcand_q};
		case ({mplr_q[1:0], prev_q})
			3'b001, 3'b010: pp = mcand_sx;
			3'b011:         pp = mcand_sx << 1;
			3'b100:         pp = -(mcand_sx << 1);
			3'b101, 3'b110: pp = -mcand_sx;
			default:        pp = '0;
		endcase
		sum = acc_q + pp;
	end

	// control
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state_q <= s_idle;
		end else begin
			case (state_q)
				s_idle: begin
					if (start) begin
						state_q <= s_run;
					end
				end
				s_run: begin
					// last digit retires this cycle
					if (cnt_q == 6'd1) begin
						state_q <= s_done;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (state_q == s_idle && start) begin
			mcand_q <= a_ext;
			mplr_q  <= b_ext;
			acc_q   <= '0;
			prev_q  <= 1'b0;
			word_q  <= word;
			cnt_q   <= word ? 6'(muldiv_pkg::mul_iters_word) : 6'(muldiv_pkg::mul_iters);
		end else if (state_q == s_run) begin
			// arithmetic shift of {acc, mplr} by two
			acc_q  <= {{2{sum[muldiv_pkg::xlen+3]}}, sum[muldiv_pkg::xlen+3:2]};
			mplr_q <= {sum[1:0], mplr_q[muldiv_pkg::xlen+1:2]};
			prev_q <= mplr_q[1];
			cnt_q  <= cnt_q - 6'd1;
		end
	end

	assign busy = (state_q == s_run);
	assign done = (state_q == s_done);

	// product layout depends on how far the multiplier got shifted
	always_comb begin
		if (word_q) begin
			// 34 steps of shift, low product bits sit in mplr_q[65:32]
			product_lo = {acc_q[29:0], mplr_q[65:32]};
			product_hi = {{26{acc_q[67]}}, acc_q[67:30]};
		end else begin
			product_lo = mplr_q[63:0];
			product_hi = {acc_q[61:0], mplr_q[65:64]};
		end
	end

	// dispatcher must wait for the engine to finish
	assert property (@(posedge clk) disable iff (rst) start |-> !busy)
		else $error("multiplier started while busy");

endmodule

`default_nettype wire

/* muldiv_dispatch.sv */
`default_nettype none

// accepts one m operation, starts the matching engine and holds its result
module muldiv_dispatch (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     in_valid,
	input  wire muldiv_pkg::md_op_e op,
	input  wire                     word,
	input  wire muldiv_pkg::xlen_t  src_a,
	input  wire muldiv_pkg::xlen_t  src_b,
	input  wire                     out_ready,
	input  wire                     flush,
	input  wire                     mul_busy,
	input  wire                     mul_done,
	input  wire muldiv_pkg::xlen_t  product_hi,
	input  wire muldiv_pkg::xlen_t  product_lo,
	input  wire                     div_busy,
	input  wire                     div_done,
	input  wire muldiv_pkg::xlen_t  quotient,
	input  wire muldiv_pkg::xlen_t  remainder,
	output logic                    in_ready,
	output logic                    out_valid,
	output muldiv_pkg::xlen_t       result,
	output logic                    mul_start,
	output logic                    div_start,
	output logic                    eng_word,
	output logic                    sign_a,
	output logic                    sign_b,
	output muldiv_pkg::xlen_t       opnd_a,
	output muldiv_pkg::xlen_t       opnd_b
);

	typedef enum logic [1:0] {
		s_idle,
		s_wait_engine,
		s_hold_result
	} state_e;

	state_e             state_q;
	muldiv_pkg::md_op_e op_q;
	logic               word_q;
	muldiv_pkg::xlen_t  result_q;

	logic               accept;
	logic               is_mul;
	logic               eng_done;
	muldiv_pkg::xlen_t  sel;
	muldiv_pkg::word_t  sel_word;
	muldiv_pkg::xlen_t  sel_ext;

	// ******************************************************************
	// input side
	// ******************************************************************

	// both engines idle and nothing held
	assign in_ready = (state_q == s_idle) && !mul_busy && !div_busy;
	// flush in the same cycle drops the operation
	assign accept   = in_valid && in_ready && !flush;
	assign is_mul   = op inside {muldiv_pkg::op_mul, muldiv_pkg::op_mulh,
		muldiv_pkg::op_mulhsu, muldiv_pkg::op_mulhu};

	assign mul_start = accept && is_mul;
	assign div_start = accept && !is_mul;
	// engines latch these on start
	assign eng_word  = word;
	assign opnd_a    = src_a;
	assign opnd_b    = src_b;

	// signedness per operand
	always_comb begin
		case (op)
			muldiv_pkg::op_mulhsu: begin
				sign_a = 1'b1;
				sign_b = 1'b0;
			end
			muldiv_pkg::op_mulhu, muldiv_pkg::op_divu, muldiv_pkg::op_remu: begin
				sign_a = 1'b0;
				sign_b = 1'b0;
			end
			default: begin
				sign_a = 1'b1;
				sign_b = 1'b1;
			end
		endcase
	end

	// ******************************************************************
	// result select
	// ******************************************************************
	assign eng_done = mul_done || div_done;

	always_comb begin
		case (op_q)
			muldiv_pkg::op_mul:                       sel = product_lo;
			muldiv_pkg::op_mulh, muldiv_pkg::op_mulhsu,
			muldiv_pkg::op_mulhu:                     sel = product_hi;
			muldiv_pkg::op_div, muldiv_pkg::op_divu:  sel = quotient;
			default:                                  sel = remainder;
		endcase
		sel_word = sel[muldiv_pkg::half_xlen-1:0];
		// *w results sign extend from bit 31
		sel_ext  = word_q ? {{muldiv_pkg::half_xlen{sel_word[muldiv_pkg::half_xlen-1]}}, sel_word}
			: sel;
	end

	// fsm
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state_q <= s_idle;
		end else begin
			case (state_q)
				s_idle: begin
					if (accept) begin
						state_q <= s_wait_engine;
					end
				end
				s_wait_engine: begin
					if (eng_done) begin
						state_q <= s_hold_result;
					end
				end
				s_hold_result: begin
					if (out_ready) begin
						state_q <= s_idle;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	// operation kind and captured result
	always_ff @(posedge clk) begin
		if (accept) begin
			op_q   <= op;
			word_q <= word;
		end
		if (state_q == s_wait_engine && eng_done) begin
			result_q <= sel_ext;
		end
	end

	assign out_valid = (state_q == s_hold_result);
	assign result    = result_q;

	// held result stays put while the consumer stalls
	assert property (@(posedge clk) disable iff (rst || flush)
		out_valid && !out_ready |=> out_valid && $stable(result))
		else $error("result moved under back-pressure");

	// no word form of the high-half multiplies
	assert property (@(posedge clk) disable iff (rst)
		in_valid && in_ready |-> !(word && op inside {muldiv_pkg::op_mulh,
		muldiv_pkg::op_mulhsu, muldiv_pkg::op_mulhu}))
		else $error("word flag with a mulh variant");

	// engines answer only while an operation is outstanding
	assert property (@(posedge clk) disable iff (rst)
		mul_done || div_done |-> state_q == s_wait_engine)
		else $error("engine done outside wait_engine");

endmodule

`default_nettype wire

/* muldiv_pkg.sv */
`default_nettype none

// ********************************************************************
// shared widths, data types and the operation code of the m unit
// ********************************************************************
package muldiv_pkg;

	// register width, one full word of the core
	localparam int xlen = 64;

	// width of the *w operations
	localparam int half_xlen = 32;

	// operands, product halves, quotient, remainder and result
	typedef logic [xlen-1:0] xlen_t;

	// low word of a word result, before sign extension
	typedef logic [half_xlen-1:0] word_t;

	// operation kind, the word flag travels separately
	typedef enum logic [2:0] {
		op_mul,
		op_mulh,
		op_mulhsu,
		op_mulhu,
		op_div,
		op_divu,
		op_rem,
		op_remu
	} md_op_e;

	// ******************************************************************
	// engine step counts
	// ******************************************************************

	// booth steps for a full multiply
	// 66 operand bits, two per step
	localparam int mul_iters = 33;

	// booth steps for a word multiply, 34 bits
	localparam int mul_iters_word = 17;

	// one quotient bit per step
	localparam int div_iters = 64;

	// word divide only walks the low half
	localparam int div_iters_word = 32;

endpackage

`default_nettype wire

/* muldiv_unit.sv */
`default_nettype none

// m extension execution unit, dispatcher plus booth and divide engines
module muldiv_unit (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     in_valid,
	input  wire muldiv_pkg::md_op_e op,
	input  wire                     word,
	input  wire muldiv_pkg::xlen_t  src_a,
	input  wire muldiv_pkg::xlen_t  src_b,
	input  wire                     out_ready,
	input  wire                     flush,
	output logic                    in_ready,
	output logic                    out_valid,
	output muldiv_pkg::xlen_t       result
);

	// ******************************************************************
	// dispatcher to engine wiring
	// ******************************************************************
	logic              mul_start;
	logic              div_start;
	logic              eng_word;
	logic              sign_a;
	logic              sign_b;
	muldiv_pkg::xlen_t opnd_a;
	muldiv_pkg::xlen_t opnd_b;

	logic              mul_busy;
	logic              mul_done;
	muldiv_pkg::xlen_t product_hi;
	muldiv_pkg::xlen_t product_lo;

	logic              div_busy;
	logic              div_done;
	muldiv_pkg::xlen_t quotient;
	muldiv_pkg::xlen_t remainder;

	muldiv_dispatch u_dispatch (
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.op         (op),
		.word       (word),
		.src_a      (src_a),
		.src_b      (src_b),
		.out_ready  (out_ready),
		.flush      (flush),
		.mul_busy   (mul_busy),
		.mul_done   (mul_done),
		.product_hi (product_hi),
		.product_lo (product_lo),
		.div_busy   (div_busy),
		.div_done   (div_done),
		.quotient   (quotient),
		.remainder  (remainder),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.result     (result),
		.mul_start  (mul_start),
		.div_start  (div_start),
		.eng_word   (eng_word),
		.sign_a     (sign_a),
		.sign_b     (sign_b),
		.opnd_a     (opnd_a),
		.opnd_b     (opnd_b)
	);

	booth_multiplier u_mul (
		.clk          (clk),
		.rst          (rst),
		.start        (mul_start),
		.flush        (flush),
		.word         (eng_word),
		.sign_a       (sign_a),
		.sign_b       (sign_b),
		.multiplicand (opnd_a),
		.multiplier   (opnd_b),
		.busy         (mul_busy),
		.done         (mul_done),
		.product_hi   (product_hi),
		.product_lo   (product_lo)
	);

	// divide signedness is the same for both operands
	restoring_divider u_div (
		.clk       (clk),
		.rst       (rst),
		.start     (div_start),
		.flush     (flush),
		.word      (eng_word),
		.sign      (sign_a),
		.dividend  (opnd_a),
		.divisor   (opnd_b),
		.busy      (div_busy),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

endmodule

`default_nettype wire

/* restoring_divider.sv */
`default_nettype none

// iterative radix-2 restoring divider, one quotient bit per cycle
// riscv rules for zero divisor and signed overflow
module restoring_divider (
	input  wire                    clk,
	input  wire                    rst,
	input  wire                    start,
	input  wire                    flush,
	input  wire                    word,
	input  wire                    sign,
	input  wire muldiv_pkg::xlen_t dividend,
	input  wire muldiv_pkg::xlen_t divisor,
	output logic                   busy,
	output logic                   done,
	output muldiv_pkg::xlen_t      quotient,
	output muldiv_pkg::xlen_t      remainder
);

	typedef enum logic [1:0] {
		s_idle,
		s_run,
		s_done
	} state_e;

	state_e state_q;

	muldiv_pkg::xlen_t a_ext;
	muldiv_pkg::xlen_t b_ext;
	muldiv_pkg::xlen_t a_abs;
	muldiv_pkg::xlen_t b_abs;
	muldiv_pkg::xlen_t min_val;
	logic              a_neg;
	logic              b_neg;
	logic              div_zero;
	logic              ovf;

	muldiv_pkg::xlen_t dvsr_q;
	muldiv_pkg::xlen_t rem_q;
	// dividend bits shift out at the top, quotient bits shift in below
	muldiv_pkg::xlen_t quo_q;
	logic              neg_quo_q;
	logic              neg_rem_q;
	logic [6:0]        cnt_q;

	logic [muldiv_pkg::xlen:0] shifted;
	logic [muldiv_pkg::xlen:0] diff;
	logic                      fits;

	// ******************************************************************
	// operand prep and special cases
	// ******************************************************************
	always_comb begin
		if (word) begin
			a_ext = {{muldiv_pkg::half_xlen{sign & dividend[31]}},
				dividend[muldiv_pkg::half_xlen-1:0]};
			b_ext = {{muldiv_pkg::half_xlen{sign & divisor[31]}},
				divisor[muldiv_pkg::half_xlen-1:0]};
			// -2^31 after sign extension
			min_val = {{(muldiv_pkg::half_xlen+1){1'b1}}, {(muldiv_pkg::half_xlen-1){1'b0}}};
		end else begin
			a_ext   = dividend;
			b_ext   = divisor;
			min_val = {1'b1, {(muldiv_pkg::xlen-1){1'b0}}};
		end
		a_neg    = sign & a_ext[muldiv_pkg::xlen-1];
		b_neg    = sign & b_ext[muldiv_pkg::xlen-1];
		a_abs    = a_neg ? -a_ext : a_ext;
		b_abs    = b_neg ? -b_ext : b_ext;
		div_zero = (b_ext == '0);
		ovf      = sign & (a_ext == min_val) & (&b_ext);
	end

	// one restoring step
	always_comb begin
		shifted = {rem_q, quo_q[muldiv_pkg::xlen-1]};
		fits    = (shifted >= {1'b0, dvsr_q});
		diff    = shifted - {1'b0, dvsr_q};
	end

	// control
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			state_q <= s_idle;
		end else begin
			case (state_q)
				s_idle: begin
					if (start) begin
						// special cases finish right away
						state_q <= (div_zero || ovf) ? s_done : s_run;
					end
				end
				s_run: begin
					if (cnt_q == 7'd1) begin
						state_q <= s_done;
					end
				end
				default: begin
					state_q <= s_idle;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (state_q == s_idle && start) begin
			if (div_zero || ovf) begin
				// zero divisor: all ones, dividend; overflow: dividend, zero
				quo_q     <= div_zero ? '1 : a_ext;
				rem_q     <= div_zero ? a_ext : '0;
				neg_quo_q <= 1'b0;
				neg_rem_q <= 1'b0;
			end else begin
				dvsr_q    <= b_abs;
				rem_q     <= '0;
				// word dividend goes to the top so the walk starts at bit 31
				quo_q     <= word ? {a_abs[muldiv_pkg::half_xlen-1:0],
					{muldiv_pkg::half_xlen{1'b0}}} : a_abs;
				neg_quo_q <= a_neg ^ b_neg;
				neg_rem_q <= a_neg;
				cnt_q     <= word ? 7'(muldiv_pkg::div_iters_word) : 7'(muldiv_pkg::div_iters);
			end
		end else if (state_q == s_run) begin
			rem_q <= fits ? diff[muldiv_pkg::xlen-1:0] : shifted[muldiv_pkg::xlen-1:0];
			quo_q <= {quo_q[muldiv_pkg::xlen-2:0], fits};
			cnt_q <= cnt_q - 7'd1;
		end
	end

	assign busy = (state_q == s_run);
	assign done = (state_q == s_done);

	// sign fix-up on the way out
	assign quotient  = neg_quo_q ? -quo_q : quo_q;
	assign remainder = neg_rem_q ? -rem_q : rem_q;

	// done only after an unflushed start or run cycle
	assert property (@(posedge clk) disable iff (rst) done |-> $past((start || busy) && !flush))
		else $error("divider done without an operation");

endmodule

`default_nettype wire

/* tb_muldiv_ref.svh */
`ifndef tb_muldiv_ref_svh
`define tb_muldiv_ref_svh

// expected value of one m operation
// riscv m rules, 128-bit products, zero divisor and overflow cases
function automatic muldiv_pkg::xlen_t md_ref(
	input muldiv_pkg::md_op_e op,
	input logic               word,
	input muldiv_pkg::xlen_t  a,
	input muldiv_pkg::xlen_t  b
);
	logic [127:0]       ua;
	logic [127:0]       ub;
	logic [127:0]       sa;
	logic [127:0]       sb;
	logic [127:0]       prod;
	logic signed [63:0] sx;
	logic signed [63:0] sy;
	logic signed [31:0] wx;
	logic signed [31:0] wy;
	muldiv_pkg::word_t  w;
	muldiv_pkg::xlen_t  r;

	ua = {64'd0, a};
	ub = {64'd0, b};
	sa = {{64{a[63]}}, a};
	sb = {{64{b[63]}}, b};
	sx = a;
	sy = b;
	wx = a[31:0];
	wy = b[31:0];
	w  = '0;
	r  = '0;

	if (word) begin
		case (op)
			muldiv_pkg::op_mul: w = a[31:0] * b[31:0];
			muldiv_pkg::op_div, muldiv_pkg::op_rem: begin
				if (b[31:0] == '0) begin
					w = (op == muldiv_pkg::op_div) ? '1 : a[31:0];
				end else if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff) begin
					w = (op == muldiv_pkg::op_div) ? a[31:0] : '0;
				end else if (op == muldiv_pkg::op_div) begin
					w = wx / wy;
				end else begin
					w = wx % wy;
				end
			end
			muldiv_pkg::op_divu, muldiv_pkg::op_remu: begin
				if (b[31:0] == '0) begin
					w = (op == muldiv_pkg::op_divu) ? '1 : a[31:0];
				end else if (op == muldiv_pkg::op_divu) begin
					w = a[31:0] / b[31:0];
				end else begin
					w = a[31:0] % b[31:0];
				end
			end
			default: w = '0;
		endcase
		// word results sign extend from bit 31
		r = {{32{w[31]}}, w};
	end else begin
		case (op)
			muldiv_pkg::op_mul: r = a * b;
			muldiv_pkg::op_mulh: begin
				prod = sa * sb;
				r    = prod[127:64];
			end
			muldiv_pkg::op_mulhsu: begin
				prod = sa * ub;
				r    = prod[127:64];
			end
			muldiv_pkg::op_mulhu: begin
				prod = ua * ub;
				r    = prod[127:64];
			end
			muldiv_pkg::op_div, muldiv_pkg::op_rem: begin
				if (b == '0) begin
					r = (op == muldiv_pkg::op_div) ? '1 : a;
				end else if (a == 64'h8000_0000_0000_0000 && b == '1) begin
					r = (op == muldiv_pkg::op_div) ? a : '0;
				end else if (op == muldiv_pkg::op_div) begin
					r = sx / sy;
				end else begin
					r = sx % sy;
				end
			end
			default: begin
				// divu and remu
				if (b == '0) begin
					r = (op == muldiv_pkg::op_divu) ? '1 : a;
				end else if (op == muldiv_pkg::op_divu) begin
					r = a / b;
				end else begin
					r = a % b;
				end
			end
		endcase
	end
	return r;
endfunction

`endif

/* tb_muldiv_unit.sv */
`default_nettype none

module tb_muldiv_unit;

	localparam int clk_period    = 8;
	localparam int reset_cycles  = 10;
	localparam int n_random      = 400;
	localparam int n_stall       = 150;
	localparam int n_flush       = 60;
	localparam int n_corner_vals = 6;
	// 8 full kinds plus 5 word kinds
	localparam int n_kinds       = 13;
	localparam int n_ops         = n_random + n_kinds * n_corner_vals * n_corner_vals
		+ n_stall + 2 * n_flush;
	// 80 cycles per operation on top of reset
	localparam longint timeout   = longint'(n_ops) * 80 * clk_period
		+ reset_cycles * clk_period;

	logic               clk;
	logic               rst;
	logic               in_valid;
	muldiv_pkg::md_op_e op;
	logic               word;
	muldiv_pkg::xlen_t  src_a;
	muldiv_pkg::xlen_t  src_b;
	logic               out_ready;
	logic               flush;
	logic               in_ready;
	logic               out_valid;
	muldiv_pkg::xlen_t  result;

	// expected results in issue order
	muldiv_pkg::xlen_t  expected_q [$];

	// compare side state
	logic               stall_q;
	muldiv_pkg::xlen_t  held_q;
	muldiv_pkg::xlen_t  exp_val;
	int unsigned        n_checked;

	`include "tb_muldiv_ref.svh"

	muldiv_unit u_muldiv_unit (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.op        (op),
		.word      (word),
		.src_a     (src_a),
		.src_b     (src_b),
		.out_ready (out_ready),
		.flush     (flush),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.result    (result)
	);

	// ********************************************************************
	// clock and watchdog
	// ********************************************************************
	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#(timeout);
		abort_run("watchdog expired before all operations finished");
	end

	// ********************************************************************
	// helpers
	// ********************************************************************
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_result(input string name, input muldiv_pkg::xlen_t got,
		input muldiv_pkg::xlen_t exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
		end
	endtask

	// kinds 0..7 are full ops and 8..12 the word forms
	task automatic decode_kind(input int k, output muldiv_pkg::md_op_e o, output logic w);
		w = (k >= 8);
		case (k)
			8:       o = muldiv_pkg::op_mul;
			9:       o = muldiv_pkg::op_div;
			10:      o = muldiv_pkg::op_divu;
			11:      o = muldiv_pkg::op_rem;
			12:      o = muldiv_pkg::op_remu;
			default: o = muldiv_pkg::md_op_e'(k[2:0]);
		endcase
	endtask

	function automatic muldiv_pkg::xlen_t corner_value(input int i);
		case (i)
			0:       return 64'h0000_0000_0000_0000;
			1:       return 64'h0000_0000_0000_0001;
			// minus one as all ones
			2:       return 64'hffff_ffff_ffff_ffff;
			3:       return 64'h8000_0000_0000_0000;
			4:       return 64'h7fff_ffff_ffff_ffff;
			// most negative word without sign extension
			default: return 64'h0000_0000_8000_0000;
		endcase
	endfunction

	function automatic muldiv_pkg::xlen_t rand_operand();
		muldiv_pkg::xlen_t v;
		muldiv_pkg::word_t lo;
		case ($urandom % 5)
			0, 1: v = {$urandom, $urandom};
			2: begin
				// small magnitudes give long quotients
				v = 64'($urandom % 16);
				if ($urandom % 2) begin
					v = -v;
				end
			end
			3: v = corner_value($urandom % n_corner_vals);
			default: begin
				lo = $urandom;
				v  = {{32{lo[31]}}, lo};
			end
		endcase
		return v;
	endfunction

	// ********************************************************************
	// stimulus tasks driving on the falling edge
	// ********************************************************************
	task automatic send_op(input muldiv_pkg::md_op_e o, input logic w,
		input muldiv_pkg::xlen_t a, input muldiv_pkg::xlen_t b);
		logic accepted;
		@(negedge clk);
		in_valid = 1'b1;
		op       = o;
		word     = w;
		src_a    = a;
		src_b    = b;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = in_ready;
		end
		expected_q.push_back(md_ref(o, w, a, b));
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic send_random();
		muldiv_pkg::md_op_e o;
		logic               w;
		muldiv_pkg::xlen_t  a;
		muldiv_pkg::xlen_t  b;
		decode_kind($urandom % n_kinds, o, w);
		a = rand_operand();
		b = rand_operand();
		send_op(o, w, a, b);
	endtask

	// queue empties on the rising edge so look on the falling one
	task automatic wait_drain();
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// consumer ready about one cycle in three until the result is taken
	task automatic stall_random();
		logic taken;
		send_random();
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk);
			out_ready = ($urandom % 3 == 0);
			@(posedge clk);
			taken = out_valid && out_ready;
		end
		@(negedge clk);
		out_ready = 1'b1;
	endtask

	// drop one operation at the handshake or while in flight or held
	task automatic flush_one();
		muldiv_pkg::md_op_e o;
		logic               w;
		muldiv_pkg::xlen_t  a;
		muldiv_pkg::xlen_t  b;
		int unsigned        delay;
		decode_kind($urandom % n_kinds, o, w);
		a = rand_operand();
		b = rand_operand();
		wait_drain();
		@(negedge clk);
		// result stays held until the flush
		out_ready = 1'b0;
		if ($urandom % 4 == 0) begin
			in_valid = 1'b1;
			op       = o;
			word     = w;
			src_a    = a;
			src_b    = b;
			flush    = 1'b1;
			@(posedge clk);
			check_flag("in_ready", in_ready, 1'b1);
			@(negedge clk);
			in_valid = 1'b0;
			flush    = 1'b0;
		end else begin
			send_op(o, w, a, b);
			delay = $urandom % 72;
			repeat (delay) @(negedge clk);
			flush = 1'b1;
			@(negedge clk);
			flush = 1'b0;
			void'(expected_q.pop_back());
		end
		// unit idle again with nothing left to hand over
		@(posedge clk);
		check_flag("in_ready", in_ready, 1'b1);
		check_flag("out_valid", out_valid, 1'b0);
		@(negedge clk);
		out_ready = 1'b1;
	endtask

	// ********************************************************************
	// compare process sampling on the rising edge
	// ********************************************************************
	initial begin
		stall_q   = 1'b0;
		held_q    = '0;
		n_checked = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				stall_q = 1'b0;
			end else begin
				// stalled result must not move
				if (stall_q) begin
					check_flag("out_valid", out_valid, 1'b1);
					check_result("result", result, held_q);
				end
				if (out_valid) begin
					check_flag("in_ready", in_ready, 1'b0);
				end
				if (out_valid && out_ready) begin
					if (expected_q.size() == 0) begin
						abort_run("result handed over with no operation outstanding");
					end else begin
						exp_val = expected_q.pop_front();
						check_result("result", result, exp_val);
						n_checked++;
					end
				end
				stall_q = out_valid && !out_ready && !flush;
				held_q  = result;
			end
		end
	end

	// ********************************************************************
	// main sequence
	// ********************************************************************
	initial begin
		muldiv_pkg::md_op_e kind_op;
		logic               kind_word;
		rst       = 1'b1;
		in_valid  = 1'b0;
		op        = muldiv_pkg::op_mul;
		word      = 1'b0;
		src_a     = '0;
		src_b     = '0;
		out_ready = 1'b1;
		flush     = 1'b0;
		void'($urandom(32'ha8d3));
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("in_ready", in_ready, 1'b1);

		// random mix with the consumer always ready
		repeat (n_random) send_random();
		wait_drain();

		// every kind over every corner pair
		// covers divide by zero and overflow in full and word form
		for (int k = 0; k < n_kinds; k++) begin
			for (int i = 0; i < n_corner_vals; i++) begin
				for (int j = 0; j < n_corner_vals; j++) begin
					decode_kind(k, kind_op, kind_word);
					send_op(kind_op, kind_word, corner_value(i), corner_value(j));
				end
			end
		end
		wait_drain();

		// back-pressure
		repeat (n_stall) stall_random();
		wait_drain();

		// flush then a normal operation right after
		repeat (n_flush) begin
			flush_one();
			send_random();
		end
		wait_drain();
		repeat (4) @(posedge clk);

		if (expected_q.size() == 0 && !out_valid) begin
			$display("%0d results checked", n_checked);
			$display("Simulation passed");
			$finish;
		end else begin
			abort_run("operations still outstanding at the end of the run");
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
muldiv_pkg.sv
booth_multiplier.sv
restoring_divider.sv
muldiv_dispatch.sv
muldiv_unit.sv
tb_muldiv_unit.sv
